/* Makefile */
VERILATOR  ?= verilator
TOP        := DataMemoryUnitTb
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing --assert
SIM_ARGS   := +verilator+error+limit+1000
PASS_MSG   := Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* dv/DataMemoryUnitTb.sv */
// Testbench for the data-memory access stage
// Random loads and stores run against a byte shadow model; load data checked as rdValid arrives

`timescale 1ns/1ps
`default_nettype none

module DataMemoryUnitTb;
    import MemAccessPkg::*;

    localparam int LineBytes = DefaultLineBytes;
    localparam int LineCount = DefaultLineCount;
    localparam int MemBytes = LineBytes * LineCount;
    localparam int DrainLimit = 20;

    logic    clk;
    logic    arstN;
    logic    reqValid;
    MemReq_t req;
    logic    rdValid;
    DWord_t  rdData;
    logic    misaligned;

    // Byte model of the whole memory
    logic [7:0]  shadow [MemBytes];
    // Expected results of aligned loads, oldest first
    DWord_t      expectQ [$];
    logic [31:0] lcgState;
    int          errorCount;
    // Low until the first request is driven
    logic        started;

    DataMemoryUnit #(
        .LineBytes(LineBytes),
        .LineCount(LineCount)
    ) DUT (
        .clk       (clk),
        .arstN     (arstN),
        .reqValid  (reqValid),
        .req       (req),
        .rdValid   (rdValid),
        .rdData    (rdData),
        .misaligned(misaligned)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Address from the upper LCG bits where the period is long
    function automatic MemAddr_t randAddr();
        return MemAddr_t'(nextRand() >> 12);
    endfunction

    function automatic int byteCount(input LoadStoreType t);
        if (t == LoadStoreType_Byte || t == LoadStoreType_UnsignedByte) begin
            return 1;
        end
        if (t == LoadStoreType_HalfWord || t == LoadStoreType_UnsignedHalfWord) begin
            return 2;
        end
        if (t == LoadStoreType_Word || t == LoadStoreType_UnsignedWord) begin
            return 4;
        end
        return 8;
    endfunction

    function automatic MemAddr_t alignAddr(input MemAddr_t addr, input LoadStoreType t);
        return addr & ~MemAddr_t'(byteCount(t) - 1);
    endfunction

    // Model result from shadow bytes with sign or zero fill
    function automatic DWord_t expectedLoad(input MemAddr_t addr, input LoadStoreType t);
        int n;
        int sh;
        DWord_t raw;
        n = byteCount(t);
        raw = '0;
        for (int i = 0; i < n; i++) begin
            raw[i*8 +: 8] = shadow[(int'(addr) + i) % MemBytes];
        end
        sh = 64 - 8 * n;
        if (t == LoadStoreType_Byte || t == LoadStoreType_HalfWord || t == LoadStoreType_Word) begin
            return DWord_t'($signed(raw << sh) >>> sh);
        end
        return raw;
    endfunction

    // Drives one request for one cycle and updates the model at drive time
    task automatic issue(input logic store, input LoadStoreType t, input MemAddr_t addr,
                         input DWord_t value);
        int n;
        n = byteCount(t);
        reqValid = 1'b1;
        req = '{store: store, accessType: t, addr: addr, value: value};
        if (int'(addr) % n == 0) begin
            if (store) begin
                for (int i = 0; i < n; i++) begin
                    shadow[(int'(addr) + i) % MemBytes] = value[i*8 +: 8];
                end
            end
            else begin
                expectQ.push_back(expectedLoad(addr, t));
            end
        end
        @(posedge clk);
        #1;
        reqValid = 1'b0;
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        while (expectQ.size() != 0 && cycles < DrainLimit) begin
            @(posedge clk);
            cycles++;
        end
        if (expectQ.size() != 0) begin
            errorCount++;
            $display("Timed out with %0d loads still waiting for rdValid", expectQ.size());
        end
    endtask

    // Outputs sampled on the falling edge in mid-cycle
    always @(negedge clk) begin : monitor
        DWord_t expected;
        if (!started) begin
            assert (!rdValid && !misaligned) else begin
                errorCount++;
                $display("Error at %0d ns: output active before any request", $time);
            end
        end
        else if (rdValid) begin
            if (expectQ.size() == 0) begin
                errorCount++;
                $display("rdValid at %0d ns with no load outstanding", $time);
            end
            else begin
                expected = expectQ.pop_front();
                assert (rdData === expected) else begin
                    errorCount++;
                    $display("Error at %0d ns: load expected %h, got %h", $time, expected, rdData);
                end
            end
        end
    end

    initial begin
        MemAddr_t     a;
        LoadStoreType t;
        logic [31:0]  r;
        errorCount = 0;
        lcgState = 32'h2182f12d;
        started = 1'b0;
        arstN = 1'b0;
        reqValid = 1'b0;
        req = '0;
        repeat (8) @(posedge clk);
        #1;
        arstN = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        started = 1'b1;

        // Fill every doubleword so the model starts defined
        for (int k = 0; k < MemBytes; k += 8) begin
            issue(1'b1, LoadStoreType_DoubleWord, MemAddr_t'(k), {nextRand(), nextRand()});
        end

        // Store then load of every access kind at one address
        for (int k = 0; k < 28; k++) begin
            t = LoadStoreType'(k % 7);
            a = alignAddr(randAddr(), t);
            issue(1'b1, t, a, {nextRand(), nextRand()});
            issue(1'b0, t, a, '0);
        end

        // Narrow stores inside one doubleword
        a = alignAddr(randAddr(), LoadStoreType_DoubleWord);
        issue(1'b1, LoadStoreType_DoubleWord, a, {nextRand(), nextRand()});
        issue(1'b1, LoadStoreType_Byte, a + 16'd5, {nextRand(), nextRand()});
        issue(1'b1, LoadStoreType_HalfWord, a + 16'd2, {nextRand(), nextRand()});
        issue(1'b1, LoadStoreType_UnsignedByte, a + 16'd7, {nextRand(), nextRand()});
        issue(1'b0, LoadStoreType_DoubleWord, a, '0);

        // Mixed traffic every cycle with a quarter reusing the previous address
        for (int k = 0; k < 300; k++) begin
            r = nextRand();
            t = LoadStoreType'(r[20:18] % 3'd7);
            a = (r[27:26] == 2'b00) ? a : randAddr();
            issue(r[23], t, alignAddr(a, t), {nextRand(), nextRand()});
        end

        // Misaligned kinds followed by a read of the doubleword around them
        a = alignAddr(randAddr(), LoadStoreType_DoubleWord);
        issue(1'b1, LoadStoreType_HalfWord, a + 16'd1, {nextRand(), nextRand()});
        issue(1'b1, LoadStoreType_Word, a + 16'd2, {nextRand(), nextRand()});
        issue(1'b1, LoadStoreType_DoubleWord, a + 16'd4, {nextRand(), nextRand()});
        issue(1'b0, LoadStoreType_UnsignedHalfWord, a + 16'd3, '0);
        issue(1'b0, LoadStoreType_DoubleWord, a, '0);

        // Beyond the memory size only the low bits pick the line
        a = alignAddr(randAddr(), LoadStoreType_Word) & MemAddr_t'(MemBytes - 1);
        issue(1'b1, LoadStoreType_Word, a + MemAddr_t'(MemBytes * 3), {nextRand(), nextRand()});
        issue(1'b0, LoadStoreType_Word, a, '0);
        issue(1'b1, LoadStoreType_UnsignedHalfWord, a, {nextRand(), nextRand()});
        issue(1'b0, LoadStoreType_UnsignedHalfWord, a + MemAddr_t'(MemBytes * 5), '0);

        drain();
        repeat (2) @(posedge clk);
        $display("Data errors: %0d, assertion failures: %0d", errorCount, DUT.sva.assertFails);
        if (errorCount + DUT.sva.assertFails == 0) begin
            $display("Finished with no errors");
        end
        else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/DataMemoryUnit_sva.sv */
// Concurrent timing checks on requests and responses of the access stage
// Bound into DataMemoryUnit with alignment recomputed from the request itself

`timescale 1ns/1ps
`default_nettype none

module DataMemoryUnitSva #(
    parameter int LineBytes = MemAccessPkg::DefaultLineBytes
) (
    input logic                  clk,
    input logic                  arstN,
    input logic                  reqValid,
    input MemAccessPkg::MemReq_t req,
    input logic                  rdValid,
    input logic                  misaligned
);
    import MemAccessPkg::*;

    localparam int OffsetWidth = $clog2(LineBytes);

    logic [OffsetWidth-1:0] offset;
    logic alignedReq;
    logic loadReq;
    logic misReq;
    int   assertFails = 0;

    // Low offset bits must be zero up to the access size
    always_comb begin
        offset = req.addr[OffsetWidth-1:0];
        case (req.accessType)
            LoadStoreType_Byte, LoadStoreType_UnsignedByte: alignedReq = 1'b1;
            LoadStoreType_HalfWord, LoadStoreType_UnsignedHalfWord: alignedReq = !offset[0];
            LoadStoreType_Word, LoadStoreType_UnsignedWord: alignedReq = offset[1:0] == 2'b00;
            default: alignedReq = offset[2:0] == 3'b000;
        endcase
    end

    assign loadReq = reqValid & ~req.store & alignedReq;
    assign misReq = reqValid & ~alignedReq;

    loadAnswered: assert property (@(posedge clk) disable iff (!arstN) loadReq |=> rdValid)
        else begin
            $error("rdValid missing after aligned load");
            assertFails++;
        end

    misFlagged: assert property (@(posedge clk) disable iff (!arstN) misReq |=> misaligned)
        else begin
            $error("misaligned missing after rejected request");
            assertFails++;
        end

    // No response without its request one cycle earlier
    noStrayRead: assert property (@(posedge clk) disable iff (!arstN) !loadReq |=> !rdValid)
        else begin
            $error("rdValid without aligned load");
            assertFails++;
        end

    noStrayMis: assert property (@(posedge clk) disable iff (!arstN) !misReq |=> !misaligned)
        else begin
            $error("misaligned without rejected request");
            assertFails++;
        end

    quietInReset: assert property (@(posedge clk) !arstN |-> (!rdValid && !misaligned))
        else begin
            $error("output active during reset");
            assertFails++;
        end

endmodule

bind DataMemoryUnit DataMemoryUnitSva #(.LineBytes(LineBytes)) sva (
    .clk(clk), .arstN(arstN), .reqValid(reqValid), .req(req),
    .rdValid(rdValid), .misaligned(misaligned)
);

`default_nettype wire

/* hw/DataMemoryUnit.sv */
// Top of the data-memory access stage
// Accepts one load or store per cycle, rejects misaligned accesses
// Load data and the misaligned pulse come out one cycle after acceptance

`timescale 1ns/1ps
`default_nettype none

module DataMemoryUnit #(
    parameter int LineBytes = MemAccessPkg::DefaultLineBytes,
    parameter int LineCount = MemAccessPkg::DefaultLineCount,
    localparam int LineWidth = LineBytes * 8,
    localparam int OffsetWidth = $clog2(LineBytes),
    localparam int IndexWidth = $clog2(LineCount)
) (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  reqValid,
    input  MemAccessPkg::MemReq_t req,
    output logic                  rdValid,
    output MemAccessPkg::DWord_t  rdData,
    output logic                  misaligned
);
    import MemAccessPkg::*;

    // Address split
    logic [OffsetWidth-1:0] offset;
    logic [IndexWidth-1:0]  index;

    // Alignment and gated enables
    logic aligned;
    logic wrEn;
    logic rdEn;

    // Line-wide data paths
    logic [LineWidth-1:0] storeLine;
    logic [LineBytes-1:0] writeMask;
    logic [LineWidth-1:0] readLine;

    // Load tracking, one cycle behind the request
    logic                   loadPending;
    logic [OffsetWidth-1:0] loadOffset;
    LoadStoreType           loadType;
    logic                   misalignedQ;

    // Offset in the line, index from the bits just above
    // Higher address bits are ignored so addresses wrap
    assign offset = req.addr[OffsetWidth-1:0];
    assign index = req.addr[OffsetWidth +: IndexWidth];

    // Natural alignment, offset a multiple of the access size
    assign aligned =
        (offset & OffsetWidth'(AccessBytes(req.accessType) - 1)) == '0;

    assign wrEn = reqValid & req.store & aligned;
    assign rdEn = reqValid & ~req.store & aligned;

    StoreValueUnit #(
        .LineBytes(LineBytes)
    ) storeValueUnit (
        .offset    (offset),
        .value     (req.value),
        .accessType(req.accessType),
        .line      (storeLine),
        .writeMask (writeMask)
    );

    // Same index for both sides, only one request per cycle
    LineMemory #(
        .LineBytes(LineBytes),
        .LineCount(LineCount)
    ) lineMemory (
        .clk    (clk),
        .arstN  (arstN),
        .wrEn   (wrEn),
        .wrIndex(index),
        .wrLine (storeLine),
        .wrMask (writeMask),
        .rdEn   (rdEn),
        .rdIndex(index),
        .rdLine (readLine)
    );

    // Offset and type follow the line through the read register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            loadPending <= 1'b0;
            loadOffset  <= '0;
            loadType    <= LoadStoreType_Byte;
            misalignedQ <= 1'b0;
        end
        else begin
            loadPending <= rdEn;
            // Rejected loads and stores alike
            misalignedQ <= reqValid & ~aligned;
            if (rdEn) begin
                loadOffset <= offset;
                loadType   <= req.accessType;
            end
        end
    end

    LoadValueUnit #(
        .LineBytes(LineBytes)
    ) loadValueUnit (
        .line      (readLine),
        .offset    (loadOffset),
        .accessType(loadType),
        .value     (rdData)
    );

    assign rdValid = loadPending;
    assign misaligned = misalignedQ;

endmodule

`default_nettype wire

/* hw/LineMemory.sv */
// Local line array for the access stage
// Byte-masked writes and a registered whole-line read with one cycle latency
// The read register holds its value between reads

`timescale 1ns/1ps
`default_nettype none

module LineMemory #(
    parameter int LineBytes = MemAccessPkg::DefaultLineBytes,
    parameter int LineCount = MemAccessPkg::DefaultLineCount,
    localparam int LineWidth = LineBytes * 8,
    localparam int IndexWidth = $clog2(LineCount)
) (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  wrEn,
    input  logic [IndexWidth-1:0] wrIndex,
    input  logic [LineWidth-1:0]  wrLine,
    input  logic [LineBytes-1:0]  wrMask,
    input  logic                  rdEn,
    input  logic [IndexWidth-1:0] rdIndex,
    output logic [LineWidth-1:0]  rdLine
);

    // Storage, one entry per line
    logic [LineWidth-1:0] mem [LineCount];

    // Write side
    // Only bytes with their mask bit set change
    always_ff @(posedge clk) begin
        if (wrEn) begin
            for (int i = 0; i < LineBytes; i++) begin
                if (wrMask[i]) begin
                    mem[wrIndex][i*8 +: 8] <= wrLine[i*8 +: 8];
                end
            end
        end
    end

    // Read side
    // Whole line captured, offset handling is downstream
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rdLine <= '0;
        end
        else if (rdEn) begin
            rdLine <= mem[rdIndex];
        end
    end

endmodule

`default_nettype wire

/* hw/LoadValueUnit.sv */
// Load path of the access stage
// Picks the addressed bytes out of a read line and extends them to 64 bits
// Purely combinational, fed from the registered line and load state

`timescale 1ns/1ps
`default_nettype none

module LoadValueUnit #(
    parameter int LineBytes = MemAccessPkg::DefaultLineBytes,
    localparam int LineWidth = LineBytes * 8,
    localparam int OffsetWidth = $clog2(LineBytes)
) (
    input  logic [LineWidth-1:0]         line,
    input  logic [OffsetWidth-1:0]       offset,
    input  MemAccessPkg::LoadStoreType   accessType,
    output MemAccessPkg::DWord_t         value
);
    import MemAccessPkg::*;

    // Line moved down so the access starts at byte 0
    logic [LineWidth-1:0] shifted;
    // Low doubleword of the shifted line
    DWord_t raw;
    // Access width in bytes
    int sizeBytes;
    // Sign extension requested
    logic isSigned;
    // Fill bit for bytes above the access
    logic fillBit;

    always_comb begin
        shifted = line >> {offset, 3'b000};
        raw = shifted[63:0];
        sizeBytes = AccessBytes(accessType);

        // Doubleword needs no fill at all
        isSigned = accessType inside {
            LoadStoreType_Byte,
            LoadStoreType_HalfWord,
            LoadStoreType_Word
        };

        // Top bit of the kept bytes
        fillBit = isSigned & raw[sizeBytes * 8 - 1];

        // Keep the low bytes, replicate fill above them
        for (int i = 0; i < 8; i++) begin
            if (i < sizeBytes) begin
                value[i*8 +: 8] = raw[i*8 +: 8];
            end
            else begin
                value[i*8 +: 8] = {8{fillBit}};
            end
        end
    end

endmodule

`default_nettype wire

/* hw/MemAccessPkg.sv */
// Shared types and defaults for the data-memory access stage
// Modules import this inside their bodies and use scoped names in headers

`default_nettype none

package MemAccessPkg;

    // One data word as seen by the core
    typedef logic [63:0] DWord_t;

    // Byte address into the local line memory
    typedef logic [15:0] MemAddr_t;

    // Access kind
    // Unsigned variants zero extend on load
    typedef enum logic [2:0] {
        LoadStoreType_Byte             = 3'd0,
        LoadStoreType_UnsignedByte     = 3'd1,
        LoadStoreType_HalfWord         = 3'd2,
        LoadStoreType_UnsignedHalfWord = 3'd3,
        LoadStoreType_Word             = 3'd4,
        LoadStoreType_UnsignedWord     = 3'd5,
        LoadStoreType_DoubleWord       = 3'd6
    } LoadStoreType;

    // One request as presented with reqValid
    typedef struct packed {
        logic         store;
        LoadStoreType accessType;
        MemAddr_t     addr;
        DWord_t       value;
    } MemReq_t;

    // Bytes per line
    // Power of two and at least one doubleword
    localparam int DefaultLineBytes = 16;

    // Lines in the array, power of two
    localparam int DefaultLineCount = 16;

    // Access size in bytes for a given type
    function automatic int AccessBytes(input LoadStoreType accessType);
        case (accessType)
            LoadStoreType_Byte, LoadStoreType_UnsignedByte: begin
                return 1;
            end
            LoadStoreType_HalfWord, LoadStoreType_UnsignedHalfWord: begin
                return 2;
            end
            LoadStoreType_Word, LoadStoreType_UnsignedWord: begin
                return 4;
            end
            default: begin
                // Doubleword and the unused code
                return 8;
            end
        endcase
    endfunction

endpackage

`default_nettype wire

/* hw/StoreValueUnit.sv */
// Store path of the access stage
// Moves a store value to its byte position in a line and builds the byte mask

`timescale 1ns/1ps
`default_nettype none

module StoreValueUnit #(
    parameter int LineBytes = MemAccessPkg::DefaultLineBytes,
    localparam int LineWidth = LineBytes * 8,
    localparam int OffsetWidth = $clog2(LineBytes)
) (
    input  logic [OffsetWidth-1:0]       offset,
    input  MemAccessPkg::DWord_t         value,
    input  MemAccessPkg::LoadStoreType   accessType,
    output logic [LineWidth-1:0]         line,
    output logic [LineBytes-1:0]         writeMask
);
    import MemAccessPkg::*;

    // Mask of access size, before shifting to the offset
    logic [LineBytes-1:0] baseMask;

    always_comb begin
        // Widen to line size, upper bytes are zero
        // Byte i of value lands at line byte offset + i
        line = LineWidth'(value) << {offset, 3'b000};
    end

    always_comb begin
        baseMask = '0;
        // Low AccessBytes bits set
        // Never more than eight, a line holds at least that
        for (int i = 0; i < 8; i++) begin
            baseMask[i] = (i < AccessBytes(accessType));
        end
        // Only covered bytes enabled
        writeMask = baseMask << offset;
    end

endmodule

`default_nettype wire

/* vlog.f */
hw/MemAccessPkg.sv
hw/StoreValueUnit.sv
hw/LoadValueUnit.sv
hw/LineMemory.sv
hw/DataMemoryUnit.sv
dv/DataMemoryUnit_sva.sv
dv/DataMemoryUnitTb.sv
